/* src/synth_pkg.sv */
package synth_pkg;

  localparam int AUDIO_WIDTH = 16;
  localparam int PERIOD_WIDTH = 24;
  localparam int NOTE_WIDTH = 7;
  localparam int ENV_STEP_WIDTH = 16;
  localparam int WB_ADDR_WIDTH = 3;
  localparam int WB_DATA_WIDTH = 32;

  typedef logic [AUDIO_WIDTH-1:0] audio_t;
  typedef logic [PERIOD_WIDTH-1:0] period_t;
  typedef logic [NOTE_WIDTH-1:0] note_t;
  typedef logic [NOTE_WIDTH-1:0] velocity_t;
  typedef logic [1:0] wave_sel_t;
  typedef logic [ENV_STEP_WIDTH-1:0] env_step_t;
  typedef logic [WB_ADDR_WIDTH-1:0] wb_addr_t;
  typedef logic [WB_DATA_WIDTH-1:0] wb_data_t;

  // waveform select codes.
  localparam wave_sel_t WAVE_NONE = 2'd0;
  localparam wave_sel_t WAVE_SINE = 2'd1;
  localparam wave_sel_t WAVE_PULSE = 2'd2;
  localparam wave_sel_t WAVE_TRIANGLE = 2'd3;

  // register word addresses.
  localparam wb_addr_t REG_WAVE = 3'd0;
  localparam wb_addr_t REG_DUTY = 3'd1;
  localparam wb_addr_t REG_ATTACK = 3'd2;
  localparam wb_addr_t REG_DECAY = 3'd3;
  localparam wb_addr_t REG_SUSTAIN = 3'd4;
  localparam wb_addr_t REG_RELEASE = 3'd5;

  localparam audio_t AUDIO_FULL_SCALE = '1;

  // shift ahead of the velocity multiply.
  localparam int PERCENT_WIDTH = 7;

  // top octave, notes 120 to 131 at 50 MHz.
  localparam int TOP_OCTAVE = 10;
  localparam period_t BASE_PERIOD [12] = '{
    24'd5972, 24'd5637, 24'd5321, 24'd5022,
    24'd4740, 24'd4474, 24'd4223, 24'd3986,
    24'd3762, 24'd3551, 24'd3352, 24'd3164
  };

endpackage : synth_pkg

/* src/param_regs.sv */
`timescale 1ns/1ps

module param_regs import synth_pkg::*; (
  input  logic      clock_50_000_000,
  input  logic      rst_n,
  input  logic      cyc,
  input  logic      stb,
  input  logic      we,
  input  wb_addr_t  adr,
  input  wb_data_t  dat_w,
  output wb_data_t  dat_r,
  output logic      ack,
  output wave_sel_t wave,
  output period_t   duty_cycle,
  output env_step_t attack_step,
  output env_step_t decay_step,
  output audio_t    sustain_level,
  output env_step_t release_step
);

  logic access;
  wb_data_t read_value;

  assign access = cyc && stb && !ack; // new request, not yet acked.

  always_comb begin
    read_value = '0;
    unique case (adr)
      REG_WAVE:    read_value = wb_data_t'(wave);
      REG_DUTY:    read_value = wb_data_t'(duty_cycle);
      REG_ATTACK:  read_value = wb_data_t'(attack_step);
      REG_DECAY:   read_value = wb_data_t'(decay_step);
      REG_SUSTAIN: read_value = wb_data_t'(sustain_level);
      REG_RELEASE: read_value = wb_data_t'(release_step);
      default:     read_value = '0; // unused addresses.
    endcase
  end

  always_ff @(posedge clock_50_000_000 or negedge rst_n) begin
    if (!rst_n) begin
      ack           <= 1'b0;
      dat_r         <= '0;
      wave          <= WAVE_NONE;
      duty_cycle    <= '0;
      attack_step   <= '0;
      decay_step    <= '0;
      sustain_level <= '0;
      release_step  <= '0;
    end else begin
      ack <= access;
      if (access && !we) dat_r <= read_value;
      if (access && we) begin
        unique case (adr)
          REG_WAVE:    wave          <= dat_w[$bits(wave_sel_t)-1:0];
          REG_DUTY:    duty_cycle    <= dat_w[$bits(period_t)-1:0];
          REG_ATTACK:  attack_step   <= dat_w[$bits(env_step_t)-1:0];
          REG_DECAY:   decay_step    <= dat_w[$bits(env_step_t)-1:0];
          REG_SUSTAIN: sustain_level <= dat_w[$bits(audio_t)-1:0];
          REG_RELEASE: release_step  <= dat_w[$bits(env_step_t)-1:0];
          default: ;
        endcase
      end
    end
  end

endmodule : param_regs

/* src/period_lut.sv */
`timescale 1ns/1ps

module period_lut import synth_pkg::*; (
  input  note_t   note_number,
  output period_t period
);

  logic [3:0] semitone;
  logic [3:0] octave;
  logic [3:0] shift;
  period_t base;

  // divide by twelve, octave 10 holds notes 120 to 127.
  assign semitone = 4'(note_number % 7'd12);
  assign octave   = 4'(note_number / 7'd12);

  // lower octaves double the period per step.
  assign shift = 4'(TOP_OCTAVE) - octave;

  always_comb begin
    base = BASE_PERIOD[0];
    for (int i = 0; i < 12; i++) begin
      if (semitone == 4'(i)) base = BASE_PERIOD[i];
    end
  end

  assign period = base << shift; // note 0 still fits in 24 bits.

endmodule : period_lut

/* src/oscillator.sv */
`timescale 1ns/1ps

module oscillator import synth_pkg::*; (
  input  logic    clock_50_000_000,
  input  logic    rst_n,
  input  logic    clear,
  input  period_t period,
  input  period_t duty_cycle,
  output audio_t  sine,
  output audio_t  pulse,
  output audio_t  triangle
);

  localparam int DIV_BITS = 34;

  period_t phase;
  period_t period_q;
  period_t duty_q;
  logic [PERIOD_WIDTH:0] phase_next;
  logic wrap;
  logic rising;

  // step per cycle in 16.16, 2^33 / period from a bit-serial divider.
  logic [DIV_BITS-1:0] div_num;
  logic [DIV_BITS-1:0] div_quot;
  logic [PERIOD_WIDTH:0] div_rem;
  logic [PERIOD_WIDTH:0] div_shift;
  logic [5:0] div_count;
  logic [31:0] step;
  logic [32:0] tri_acc;

  audio_t tri_level;
  audio_t fold;
  logic [2*AUDIO_WIDTH-1:0] square;

  assign phase_next = {1'b0, phase} + 1'b1;
  assign wrap       = phase_next >= {1'b0, period_q};
  assign rising     = phase < (period_q >> 1);
  assign div_shift  = {div_rem[PERIOD_WIDTH-1:0], div_num[DIV_BITS-1]};
  assign tri_level  = tri_acc[31:16];

  // parabola on each half of the triangle gives the sine shape.
  assign fold   = tri_level[15] ? ~tri_level : tri_level;
  assign square = fold * fold;

  always_ff @(posedge clock_50_000_000 or negedge rst_n) begin
    if (!rst_n) begin
      phase     <= '0;
      period_q  <= '0;
      duty_q    <= '0;
      div_num   <= '0;
      div_quot  <= '0;
      div_rem   <= '0;
      div_count <= '0;
      step      <= '0;
      tri_acc   <= '0;
    end else begin
      if (clear || wrap) begin
        phase     <= '0;
        period_q  <= period; // new period and duty from here on.
        duty_q    <= duty_cycle;
        tri_acc   <= '0;
        div_num   <= DIV_BITS'(1) << (DIV_BITS - 1);
        div_rem   <= '0;
        div_count <= 6'(DIV_BITS);
      end else begin
        phase <= phase_next[PERIOD_WIDTH-1:0];
        if (rising) begin
          tri_acc <= (tri_acc + step > 33'hffff_ffff) ? 33'hffff_ffff : tri_acc + step;
        end else begin
          tri_acc <= (tri_acc > {1'b0, step}) ? tri_acc - step : '0;
        end
        if (div_count != '0) begin
          div_num   <= div_num << 1;
          div_count <= div_count - 1'b1;
          if (div_shift >= {1'b0, period_q}) begin
            div_rem  <= div_shift - {1'b0, period_q};
            div_quot <= {div_quot[DIV_BITS-2:0], 1'b1};
          end else begin
            div_rem  <= div_shift;
            div_quot <= {div_quot[DIV_BITS-2:0], 1'b0};
          end
        end else if (div_num == '0 && period_q != '0) begin
          step    <= div_quot[31:0];
          div_num <= {DIV_BITS{1'b1}}; // latched, wait for the next wrap.
        end
      end
    end
  end

  always_ff @(posedge clock_50_000_000 or negedge rst_n) begin
    if (!rst_n) begin
      pulse    <= '0;
      triangle <= '0;
      sine     <= '0;
    end else begin
      pulse    <= (phase < duty_q) ? AUDIO_FULL_SCALE : '0;
      triangle <= tri_level;
      sine     <= tri_level[15] ? ~audio_t'(square >> 15) : audio_t'(square >> 15);
    end
  end

endmodule : oscillator

/* src/envelope.sv */
`timescale 1ns/1ps

module envelope import synth_pkg::*; #(
  parameter int ENV_PRESCALE = 256
) (
  input  logic      clock_50_000_000,
  input  logic      rst_n,
  input  logic      note_start,
  input  logic      note_stop,
  input  env_step_t attack_step,
  input  env_step_t decay_step,
  input  audio_t    sustain_level,
  input  env_step_t release_step,
  output audio_t    envelope,
  output logic      envelope_end
);

  localparam int PRESCALE_W = $clog2(ENV_PRESCALE + 1);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_ATTACK,
    ST_DECAY,
    ST_SUSTAIN,
    ST_RELEASE
  } env_state_t;

  env_state_t state;
  logic [PRESCALE_W-1:0] prescale;
  logic tick;
  logic [AUDIO_WIDTH:0] headroom;
  logic [AUDIO_WIDTH:0] above_sustain;

  assign tick          = prescale == PRESCALE_W'(ENV_PRESCALE - 1);
  assign headroom      = {1'b0, AUDIO_FULL_SCALE} - {1'b0, envelope};
  assign above_sustain = {1'b0, envelope} - {1'b0, sustain_level};
  assign envelope_end  = state == ST_IDLE;

  always_ff @(posedge clock_50_000_000 or negedge rst_n) begin
    if (!rst_n) begin
      state    <= ST_IDLE;
      prescale <= '0;
      envelope <= '0;
    end else if (note_start) begin
      state    <= ST_ATTACK; // restart from zero in any state.
      prescale <= '0;
      envelope <= '0;
    end else begin
      prescale <= tick ? '0 : prescale + 1'b1;
      if (note_stop && state != ST_IDLE) state <= ST_RELEASE;
      else if (tick) begin
        unique case (state)
          ST_IDLE: envelope <= '0;
          ST_ATTACK: begin
            if (attack_step == '0 || headroom <= {1'b0, attack_step}) begin
              envelope <= AUDIO_FULL_SCALE;
              state    <= ST_DECAY;
            end else begin
              envelope <= envelope + attack_step;
            end
          end
          ST_DECAY: begin
            if (decay_step == '0 || envelope <= sustain_level ||
                above_sustain <= {1'b0, decay_step}) begin
              envelope <= sustain_level;
              state    <= ST_SUSTAIN;
            end else begin
              envelope <= envelope - decay_step;
            end
          end
          ST_SUSTAIN: envelope <= sustain_level; // follows register writes.
          ST_RELEASE: begin
            if (release_step == '0 || envelope <= release_step) begin
              envelope <= '0;
              state    <= ST_IDLE;
            end else begin
              envelope <= envelope - release_step;
            end
          end
          default: state <= ST_IDLE;
        endcase
      end
    end
  end

endmodule : envelope

/* src/voice_pipeline.sv */
`timescale 1ns/1ps

module voice_pipeline import synth_pkg::*; #(
  parameter int ENV_PRESCALE = 256
) (
  input  logic      clock_50_000_000,
  input  logic      rst_n,
  input  note_t     note_number,
  input  velocity_t velocity,
  input  logic      note_on,
  input  logic      note_valid,
  input  wave_sel_t wave,
  input  period_t   duty_cycle,
  input  env_step_t attack_step,
  input  env_step_t decay_step,
  input  audio_t    sustain_level,
  input  env_step_t release_step,
  output audio_t    audio
);

  note_t     note_q;
  velocity_t velocity_q;
  logic      on_q;
  logic      valid_q;
  logic      note_start;
  logic      note_stop;

  period_t period;
  audio_t  sine;
  audio_t  pulse;
  audio_t  triangle;
  audio_t  env_level;
  logic    envelope_end;

  audio_t selected;
  audio_t scaled;
  logic [2*AUDIO_WIDTH-1:0] env_product;
  logic [AUDIO_WIDTH+NOTE_WIDTH-1:0] vel_product;

  always_ff @(posedge clock_50_000_000 or negedge rst_n) begin
    if (!rst_n) begin
      note_q     <= '0;
      velocity_q <= '0;
      on_q       <= 1'b0;
      valid_q    <= 1'b0;
    end else begin
      valid_q <= note_valid;
      if (note_valid) begin
        note_q     <= note_number;
        velocity_q <= velocity;
        on_q       <= note_on;
      end
    end
  end

  assign note_start = valid_q && on_q;
  assign note_stop  = valid_q && !on_q;

  period_lut period_lut_i (
    .note_number(note_q),
    .period
  );

  oscillator oscillator_i (
    .clock_50_000_000,
    .rst_n,
    .clear(note_start),
    .period,
    .duty_cycle,
    .sine,
    .pulse,
    .triangle
  );

  envelope #(.ENV_PRESCALE(ENV_PRESCALE)) envelope_i (
    .clock_50_000_000,
    .rst_n,
    .note_start,
    .note_stop,
    .attack_step,
    .decay_step,
    .sustain_level,
    .release_step,
    .envelope(env_level),
    .envelope_end
  );

  assign env_product = selected * env_level;
  assign vel_product = (scaled >> PERCENT_WIDTH) * velocity_q;

  always_ff @(posedge clock_50_000_000 or negedge rst_n) begin
    if (!rst_n) begin
      selected <= '0;
      scaled   <= '0;
      audio    <= '0;
    end else if (envelope_end) begin
      selected <= '0; // voice idle, flush every stage.
      scaled   <= '0;
      audio    <= '0;
    end else begin
      unique case (wave)
        WAVE_SINE:     selected <= sine;
        WAVE_PULSE:    selected <= pulse;
        WAVE_TRIANGLE: selected <= triangle;
        default:       selected <= '0;
      endcase
      scaled <= env_product[2*AUDIO_WIDTH-1:AUDIO_WIDTH]; // high half.
      audio  <= vel_product[AUDIO_WIDTH-1:0];
    end
  end

endmodule : voice_pipeline

/* src/synth_voice_top.sv */
`timescale 1ns/1ps

module synth_voice_top import synth_pkg::*; #(
  parameter int ENV_PRESCALE = 256
) (
  input  logic      clock_50_000_000,
  input  logic      rst_n,
  input  logic      cyc,
  input  logic      stb,
  input  logic      we,
  input  wb_addr_t  adr,
  input  wb_data_t  dat_w,
  output wb_data_t  dat_r,
  output logic      ack,
  input  note_t     note_number,
  input  velocity_t velocity,
  input  logic      note_on,
  input  logic      note_valid,
  output audio_t    audio
);

  wave_sel_t wave;
  period_t   duty_cycle;
  env_step_t attack_step;
  env_step_t decay_step;
  audio_t    sustain_level;
  env_step_t release_step;

  param_regs param_regs_i (
    .clock_50_000_000,
    .rst_n,
    .cyc,
    .stb,
    .we,
    .adr,
    .dat_w,
    .dat_r,
    .ack,
    .wave,
    .duty_cycle,
    .attack_step,
    .decay_step,
    .sustain_level,
    .release_step
  );

  voice_pipeline #(.ENV_PRESCALE(ENV_PRESCALE)) voice_pipeline_i (
    .clock_50_000_000,
    .rst_n,
    .note_number,
    .velocity,
    .note_on,
    .note_valid,
    .wave,
    .duty_cycle,
    .attack_step,
    .decay_step,
    .sustain_level,
    .release_step,
    .audio
  );

endmodule : synth_voice_top

/* tests/tb_synth_voice.sv */
`timescale 1ns/1ps

module tb_synth_voice import synth_pkg::*; ();

  localparam int ENV_PRESCALE = 4;
  localparam int RELEASE_LIMIT = 65536 * ENV_PRESCALE;

  logic      clock_50_000_000 = 1'b0;
  logic      rst_n;
  logic      cyc;
  logic      stb;
  logic      we;
  wb_addr_t  adr;
  wb_data_t  dat_w;
  wb_data_t  dat_r;
  logic      ack;
  note_t     note_number;
  velocity_t velocity;
  logic      note_on;
  logic      note_valid;
  audio_t    audio;

  logic [31:0] lcg_state = 32'hdaf7d13b;

  synth_voice_top #(.ENV_PRESCALE(ENV_PRESCALE)) synth_voice_top_i (
    .clock_50_000_000,
    .rst_n,
    .cyc,
    .stb,
    .we,
    .adr,
    .dat_w,
    .dat_r,
    .ack,
    .note_number,
    .velocity,
    .note_on,
    .note_valid,
    .audio
  );

  initial begin
    forever #50 clock_50_000_000 = ~clock_50_000_000;
  end

  task automatic report_mismatch(input string name, input longint expected, input longint actual);
    $display("FAIL %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
    $display("Simulation FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic report_error(input string what);
    $display("ERROR: %s", what);
    $display("Simulation FAILED");
    $fatal(1, "stopped at first error");
  endtask

  ack_single_cycle: assert property (@(posedge clock_50_000_000) disable iff (!rst_n) ack |=> !ack)
    else report_mismatch("wb_ack_width", 0, 1);

  function logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // base period of the semitone, doubled per octave below the top one.
  function automatic int note_period(input note_t n);
    return int'(BASE_PERIOD[n % 12]) << (10 - n / 12);
  endfunction

  task automatic wb_access(input logic write, input wb_addr_t address, input wb_data_t data,
                           output wb_data_t rdata);
    int waited;
    cyc    = 1'b1;
    stb    = 1'b1;
    we     = write;
    adr    = address;
    dat_w  = data;
    waited = 0;
    do begin
      @(negedge clock_50_000_000);
      waited++;
      if (waited > 16) report_error("no Wishbone ack within 16 cycles");
    end while (!ack);
    assert (waited == 1) else report_mismatch("wb_ack_delay", 1, waited);
    rdata = dat_r;
    cyc   = 1'b0;
    stb   = 1'b0;
    we    = 1'b0;
    @(negedge clock_50_000_000);
    assert (!ack) else report_mismatch("wb_ack_drop", 0, ack);
  endtask

  task automatic reg_write(input wb_addr_t address, input wb_data_t data);
    wb_data_t unused;
    wb_access(1'b1, address, data, unused);
  endtask

  task automatic reg_read(input wb_addr_t address, output wb_data_t data);
    wb_access(1'b0, address, '0, data);
  endtask

  // returns once the note has reached audio, four cycles on.
  task automatic play_note(input note_t n, input velocity_t v, input logic on);
    note_number = n;
    velocity    = v;
    note_on     = on;
    note_valid  = 1'b1;
    @(negedge clock_50_000_000);
    note_valid = 1'b0;
    repeat (3) @(negedge clock_50_000_000);
  endtask

  task automatic wait_level(input logic want_high, input int limit, input string what,
                            output int cycles);
    cycles = 0;
    do begin
      @(negedge clock_50_000_000);
      cycles++;
      if (cycles > limit) report_error({"timeout waiting for an audio edge in ", what});
    end while ((audio != '0) != want_high);
  endtask

  task automatic measure_pulse(input int period, input int duty, input string name);
    int high;
    int low;
    int limit;
    limit = 2 * period + 16;
    wait_level(1'b1, limit, name, high); // first run is cut by the attack.
    wait_level(1'b0, limit, name, high);
    wait_level(1'b1, limit, name, low);
    repeat (3) begin
      wait_level(1'b0, limit, name, high);
      wait_level(1'b1, limit, name, low);
      assert (high == duty) else report_mismatch({name, "_duty"}, duty, high);
      assert (high + low == period) else report_mismatch({name, "_period"}, period, high + low);
    end
  endtask

  task automatic silence_voice(input int span);
    int zero_run;
    int cycles;
    reg_write(REG_RELEASE, '0);
    play_note(note_number, '0, 1'b0);
    zero_run = 0;
    cycles   = 0;
    while (zero_run < span) begin
      @(negedge clock_50_000_000);
      cycles++;
      if (cycles > span + 64) report_error("voice did not go quiet after note off");
      zero_run = (audio == '0) ? zero_run + 1 : 0;
    end
  endtask

  initial begin
    wb_data_t  wr_value [6];
    wb_data_t  width_mask [6];
    wb_data_t  rd_value;
    note_t     n;
    note_t     n2;
    velocity_t v;
    int        p;
    int        d;
    int        expected;
    int        zero_run;
    int        cycles;
    audio_t    last_peak;

    rst_n       = 1'b0;
    cyc         = 1'b0;
    stb         = 1'b0;
    we          = 1'b0;
    adr         = '0;
    dat_w       = '0;
    note_number = '0;
    velocity    = '0;
    note_on     = 1'b0;
    note_valid  = 1'b0;
    width_mask  = '{32'h3, 32'hff_ffff, 32'hffff, 32'hffff, 32'hffff, 32'hffff};

    repeat (2) begin
      @(negedge clock_50_000_000);
      assert (audio == '0) else report_mismatch("reset_audio", 0, audio);
    end
    rst_n = 1'b1;
    repeat (32) begin // no note at all.
      @(negedge clock_50_000_000);
      assert (audio == '0) else report_mismatch("idle_audio", 0, audio);
    end

    for (int i = 0; i < 6; i++) begin
      wr_value[i] = next_random();
      reg_write(wb_addr_t'(i), wr_value[i]);
    end
    for (int i = 0; i < 6; i++) begin
      reg_read(wb_addr_t'(i), rd_value);
      assert (rd_value == (wr_value[i] & width_mask[i]))
        else report_mismatch($sformatf("reg_readback_%0d", i), wr_value[i] & width_mask[i],
                             rd_value);
    end
    for (int i = 6; i < 8; i++) begin
      reg_write(wb_addr_t'(i), next_random());
      reg_read(wb_addr_t'(i), rd_value);
      assert (rd_value == '0) else report_mismatch($sformatf("reg_unused_%0d", i), 0, rd_value);
    end

    // full envelope straight away.
    reg_write(REG_ATTACK, '0);
    reg_write(REG_DECAY, next_random());
    reg_write(REG_SUSTAIN, 32'hffff);
    n = note_t'(108 + next_random() % 20);
    p = note_period(n);
    v = velocity_t'(1 + next_random() % 127);
    reg_write(REG_DUTY, p / 2);
    reg_write(REG_WAVE, WAVE_NONE);
    play_note(n, v, 1'b1);
    repeat (2 * p) begin
      @(negedge clock_50_000_000);
      assert (audio == '0) else report_mismatch("wave_none_audio", 0, audio);
    end
    silence_voice(16);

    reg_write(REG_WAVE, WAVE_PULSE);
    expected = (32'hfffe >> PERCENT_WIDTH) * v;
    play_note(n, v, 1'b1);
    wait_level(1'b1, 2 * p + 16, "pulse_level", cycles);
    wait_level(1'b0, 2 * p + 16, "pulse_level", cycles);
    repeat (2 * p) begin
      @(negedge clock_50_000_000);
      if (audio != '0)
        assert (audio == expected) else report_mismatch("pulse_level", expected, audio);
    end
    silence_voice(2 * p);

    n = note_t'(108 + next_random() % 20);
    p = note_period(n);
    d = 1 + next_random() % (p - 1);
    reg_write(REG_DUTY, d);
    play_note(n, v, 1'b1);
    measure_pulse(p, d, "pulse");

    // note from the period test keeps playing into release.
    reg_write(REG_RELEASE, 32'h40 + next_random() % 32'h3c0);
    play_note(n, v, 1'b0);
    last_peak = '1;
    zero_run  = 0;
    cycles    = 0;
    while (zero_run < 2 * p) begin
      @(negedge clock_50_000_000);
      cycles++;
      if (cycles > RELEASE_LIMIT) report_error("audio did not decay to zero after note off");
      if (audio == '0) begin
        zero_run++;
      end else begin
        assert (audio <= last_peak) else report_mismatch("release_peak", last_peak, audio);
        last_peak = audio;
        zero_run  = 0;
      end
    end
    repeat (2 * p) begin
      @(negedge clock_50_000_000);
      assert (audio == '0) else report_mismatch("release_idle", 0, audio);
    end

    d = 1 + next_random() % 3000; // below the shortest period in range.
    reg_write(REG_DUTY, d);
    reg_write(REG_RELEASE, 32'h8); // slow release.
    n  = note_t'(108 + next_random() % 20);
    n2 = note_t'(108 + (n - 108 + 1 + next_random() % 19) % 20);
    p  = note_period(n);
    play_note(n, v, 1'b1);
    wait_level(1'b1, 2 * p + 16, "retrigger_first", cycles);
    play_note(n, v, 1'b0);
    wait_level(1'b1, 2 * p + 16, "retrigger_release", cycles);
    play_note(n2, v, 1'b1);
    measure_pulse(note_period(n2), d, "retrigger");
    // envelope back at full scale, not still releasing.
    assert (audio == expected) else report_mismatch("retrigger_level", expected, audio);

    $display("Simulation PASSED");
    $finish;
  end

endmodule : tb_synth_voice

/* sim.f */
src/synth_pkg.sv
src/param_regs.sv
src/period_lut.sv
src/oscillator.sv
src/envelope.sv
src/voice_pipeline.sv
src/synth_voice_top.sv
tests/tb_synth_voice.sv

/* Bender.yml */
package:
  name: synth_voice

sources:
  - src/synth_pkg.sv
  - src/param_regs.sv
  - src/period_lut.sv
  - src/oscillator.sv
  - src/envelope.sv
  - src/voice_pipeline.sv
  - src/synth_voice_top.sv
  - target: test
    files:
      - tests/tb_synth_voice.sv
